/* Bender.yml */
package:
  name: wb_system

sources:
  - files:
      - hw/wb_pkg.sv
      - hw/wb_addr_decoder.sv
      - hw/wb_mem_bank.sv
      - hw/wb_resp_mux.sv
      - hw/wb_system.sv

  - target: test
    files:
      - bench/wb_system_checker.sv
      - bench/tb_wb_system.sv

/* bench/tb_wb_system.sv */
// ----------------------------------------------------------------------
// Wishbone memory system testbench
// Directed tests standing in for the processor core on the master port
// ----------------------------------------------------------------------
module tb_wb_system;

    import wb_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 5;
    localparam int SEED       = 73165;

    // Accesses per test, in run order
    localparam int N_ACCESSES      = 8 + 9 + 13 + 8 + 16;
    localparam int WATCHDOG_CYCLES = N_ACCESSES * 4 + 200;

    logic        clk;
    logic        rst_n;
    wb_req_t     req;
    wb_rsp_t     rsp;
    int          error_count;
    int          tests_passed;
    int          tests_failed;

    wb_system DUT (
        .i_clk   ( clk   ),
        .i_rst_n ( rst_n ),
        .i_req   ( req   ),
        .o_rsp   ( rsp   )
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------------
    // Support tasks
    // ------------------------------------------------------------------
    task automatic check_val(input string name, input logic [WB_DWIDTH-1:0] expected,
                             input logic [WB_DWIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %h, actual %h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_answer(input wb_rsp_t r, input logic exp_ack, input logic exp_err);
        check_val("o_rsp.ack", WB_DWIDTH'(exp_ack), WB_DWIDTH'(r.ack));
        check_val("o_rsp.err", WB_DWIDTH'(exp_err), WB_DWIDTH'(r.err));
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (error_count == start_errors) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, error_count - start_errors);
        end
    endtask

    function automatic logic [WB_AWIDTH-1:0] make_adr(input int region, input int word);
        logic [WB_AWIDTH-1:0] adr;
        adr = '0;
        adr[REGION_MSB:REGION_LSB] = region[REGION_W-1:0];
        adr[WORD_LSB +: BANK_AW]   = word[BANK_AW-1:0];
        return adr;
    endfunction

    // New byte where sel is set, old byte elsewhere
    function automatic logic [WB_DWIDTH-1:0] merge_lanes(input logic [WB_DWIDTH-1:0] old_word,
                                                         input logic [WB_DWIDTH-1:0] new_word,
                                                         input logic [WB_SWIDTH-1:0] sel);
        logic [WB_DWIDTH-1:0] result;
        result = old_word;
        for (int b = 0; b < WB_SWIDTH; b++) begin
            if (sel[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // One access with an idle cycle before it, waits up to 2 cycles for an answer
    task automatic run_access(input logic we, input logic [WB_AWIDTH-1:0] adr,
                              input logic [WB_SWIDTH-1:0] sel,
                              input logic [WB_DWIDTH-1:0] wdata, output wb_rsp_t result);
        bit answered;
        answered = 1'b0;
        @(negedge clk);
        req.adr = adr;
        req.sel = sel;
        req.we  = we;
        req.dat = wdata;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        for (int c = 0; c < 2 && !answered; c++) begin
            @(negedge clk);
            answered = rsp.ack || rsp.err;
        end
        result = rsp;
        req    = '0;
        if (!answered) begin
            $display("No ack or err arrived within 2 cycles for address %h at %0t", adr, $time);
            error_count++;
        end
    endtask

    task automatic wb_write(input logic [WB_AWIDTH-1:0] adr, input logic [WB_SWIDTH-1:0] sel,
                            input logic [WB_DWIDTH-1:0] wdata, output wb_rsp_t result);
        run_access(1'b1, adr, sel, wdata, result);
    endtask

    task automatic wb_read(input logic [WB_AWIDTH-1:0] adr, output wb_rsp_t result);
        run_access(1'b0, adr, '0, '0, result);
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------
    task automatic test_idle_after_reset();
        int start_errors;
        start_errors = error_count;
        repeat (10) begin
            @(negedge clk);
            check_answer(rsp, 1'b0, 1'b0);
        end
        report_test("idle after reset", start_errors);
    endtask

    task automatic test_full_word();
        int                   start_errors;
        int                   off;
        logic [WB_DWIDTH-1:0] data;
        wb_rsp_t              r;
        start_errors = error_count;
        for (int k = 0; k < N_BANKS; k++) begin
            off  = $urandom_range(BANK_WORDS - 1, 0);
            data = $urandom;
            wb_write(make_adr(k, off), '1, data, r);
            check_answer(r, 1'b1, 1'b0);
            wb_read(make_adr(k, off), r);
            check_answer(r, 1'b1, 1'b0);
            check_val("o_rsp.dat", data, r.dat);
        end
        report_test("full word", start_errors);
    endtask

    task automatic test_byte_lanes();
        logic [WB_SWIDTH-1:0] masks [3];
        int                   start_errors;
        int                   off;
        logic [WB_DWIDTH-1:0] first;
        logic [WB_DWIDTH-1:0] second;
        wb_rsp_t              r;
        start_errors = error_count;
        masks = '{4'b0001, 4'b1010, 4'b0110};
        for (int i = 0; i < 3; i++) begin
            off    = $urandom_range(BANK_WORDS - 1, 0);
            first  = $urandom;
            second = $urandom;
            wb_write(make_adr(i, off), '1, first, r);
            wb_write(make_adr(i, off), masks[i], second, r);
            check_answer(r, 1'b1, 1'b0);
            wb_read(make_adr(i, off), r);
            check_val("o_rsp.dat", merge_lanes(first, second, masks[i]), r.dat);
        end
        report_test("byte lanes", start_errors);
    endtask

    task automatic test_unmapped();
        int                   regions [3];
        int                   start_errors;
        logic [WB_DWIDTH-1:0] d0;
        logic [WB_DWIDTH-1:0] d2;
        wb_rsp_t              r;
        start_errors = error_count;
        regions = '{N_BANKS, 10, 15};
        d0 = $urandom;
        d2 = $urandom;
        wb_write(make_adr(0, 5), '1, d0, r);
        wb_write(make_adr(2, 9), '1, d2, r);
        // Same word offsets, so a misrouted write would hit the words above
        foreach (regions[i]) begin
            wb_write(make_adr(regions[i], 5), '1, ~d0, r);
            check_answer(r, 1'b0, 1'b1);
            wb_write(make_adr(regions[i], 9), '1, ~d2, r);
            check_answer(r, 1'b0, 1'b1);
            wb_read(make_adr(regions[i], 9), r);
            check_answer(r, 1'b0, 1'b1);
            check_val("o_rsp.dat", '0, r.dat);
        end
        wb_read(make_adr(0, 5), r);
        check_val("o_rsp.dat", d0, r.dat);
        wb_read(make_adr(2, 9), r);
        check_val("o_rsp.dat", d2, r.dat);
        report_test("unmapped access", start_errors);
    endtask

    task automatic test_isolation();
        logic [WB_DWIDTH-1:0] vals [N_BANKS];
        int                   start_errors;
        wb_rsp_t              r;
        start_errors = error_count;
        for (int k = 0; k < N_BANKS; k++) begin
            vals[k] = {8'(8'hA0 + k), 24'($urandom)};
            wb_write(make_adr(k, 6'h2a), '1, vals[k], r);
        end
        for (int k = 0; k < N_BANKS; k++) begin
            wb_read(make_adr(k, 6'h2a), r);
            check_val("o_rsp.dat", vals[k], r.dat);
        end
        report_test("bank isolation", start_errors);
    endtask

    // Eight writes then eight reads, the bank changes on every access
    task automatic test_back_to_back();
        logic [BANK_AW-1:0]   offs [8];
        logic [WB_DWIDTH-1:0] model [N_BANKS][BANK_WORDS];
        int                   start_errors;
        int                   bank;
        logic [BANK_AW-1:0]   off;
        logic                 prev_read;
        logic [WB_DWIDTH-1:0] prev_exp;
        start_errors = error_count;
        prev_read    = 1'b0;
        prev_exp     = '0;
        foreach (offs[i]) offs[i] = BANK_AW'($urandom_range(BANK_WORDS - 1, 0));
        for (int i = 0; i <= 16; i++) begin
            @(negedge clk);
            // Answer to the access presented one cycle earlier
            if (i > 0) begin
                check_answer(rsp, 1'b1, 1'b0);
                if (prev_read) begin
                    check_val("o_rsp.dat", prev_exp, rsp.dat);
                end
            end
            if (i < 16) begin
                bank    = i % N_BANKS;
                off     = offs[i % 8];
                req.adr = make_adr(bank, off);
                req.sel = '1;
                req.we  = (i < 8);
                req.dat = $urandom;
                req.cyc = 1'b1;
                req.stb = 1'b1;
                if (i < 8) begin
                    model[bank][off] = req.dat;
                end
                prev_read = (i >= 8);
                prev_exp  = model[bank][off];
            end else begin
                req = '0;
            end
        end
        @(negedge clk);
        check_answer(rsp, 1'b0, 1'b0);
        report_test("back to back", start_errors);
    endtask

    // ------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------
    initial begin
        void'($urandom(SEED));
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        req          = '0;
        rst_n        = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        test_idle_after_reset();
        test_full_word();
        test_byte_lanes();
        test_unmapped();
        test_isolation();
        test_back_to_back();

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (error_count == 0 && tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #((RST_CYCLES + WATCHDOG_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* bench/wb_system_checker.sv */
// ----------------------------------------------------------------------
// Wishbone fabric protocol checker
// Concurrent assertions on the master response and on each responder
// ----------------------------------------------------------------------
module wb_system_checker (
    input logic            i_clk,
    input logic            i_rst_n,
    input wb_pkg::wb_req_t i_req,
    input wb_pkg::wb_rsp_t i_rsp,
    input wb_pkg::wb_rsp_t i_bank_rsp [wb_pkg::N_BANKS],
    input wb_pkg::wb_rsp_t i_dec_rsp
);

    import wb_pkg::*;

    // High from the second reset cycle on, once the response flops are cleared
    logic rst_seen = 1'b0;

    always @(posedge i_clk) begin
        rst_seen <= !i_rst_n;
    end

    a_ack_err_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_rsp.ack && i_rsp.err))
        else $error("ack and err high in the same cycle");

    a_answer_needs_request: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_rsp.ack || i_rsp.err) |-> $past(i_req.cyc && i_req.stb))
        else $error("answer without a request in the previous cycle");

    a_quiet_in_reset: assert property (@(posedge i_clk)
        (!i_rst_n && rst_seen) |-> (!i_rsp.ack && !i_rsp.err))
        else $error("answer while reset is low");

    // A responder never answers in two consecutive cycles
    a_dec_no_repeat: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_dec_rsp.err |=> !i_dec_rsp.err)
        else $error("decoder err in two consecutive cycles");

    for (genvar k = 0; k < N_BANKS; k++) begin : g_bank_chk
        a_bank_no_repeat: assert property (@(posedge i_clk) disable iff (!i_rst_n)
            i_bank_rsp[k].ack |=> !i_bank_rsp[k].ack)
            else $error("bank ack in two consecutive cycles");
    end

endmodule

bind wb_system wb_system_checker u_checker (
    .i_clk      ( i_clk    ),
    .i_rst_n    ( i_rst_n  ),
    .i_req      ( i_req    ),
    .i_rsp      ( o_rsp    ),
    .i_bank_rsp ( bank_rsp ),
    .i_dec_rsp  ( dec_rsp  )
);

/* hw/wb_addr_decoder.sv */
// ----------------------------------------------------------------------
// Wishbone address decoder
// Turns the region nibble into a one-hot bank select and answers
// accesses to unmapped regions with a single-cycle error
// ----------------------------------------------------------------------
module wb_addr_decoder (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  wb_pkg::wb_req_t   i_req,
    output wb_pkg::bank_sel_t o_bank_sel,
    output wb_pkg::wb_rsp_t   o_rsp
);

    import wb_pkg::*;

    logic [REGION_W-1:0] region;
    logic                req_live;
    logic                unmapped;
    logic                err_q;

    assign region   = i_req.adr[REGION_MSB:REGION_LSB];
    assign req_live = i_req.cyc & i_req.stb;

    // Regions at or above the bank count have no slave behind them
    assign unmapped = (region >= REGION_W'(N_BANKS));

    // ------------------------------------------------------------------
    // Bank select, purely combinational
    // ------------------------------------------------------------------
    always_comb begin
        o_bank_sel = '0;
        for (int k = 0; k < N_BANKS; k++) begin
            if (region == REGION_W'(k)) begin
                o_bank_sel[k] = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Error response
    // ------------------------------------------------------------------
    // Blocked in the cycle after an error, otherwise a request still
    // held by the master would be answered twice
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req_live & unmapped & ~err_q;
        end
    end

    // The decoder never acks and carries no data
    assign o_rsp.dat = '0;
    assign o_rsp.ack = 1'b0;
    assign o_rsp.err = err_q;

endmodule

/* hw/wb_mem_bank.sv */
// ----------------------------------------------------------------------
// Wishbone on-chip memory bank
// Word-addressed RAM with byte-lane writes, registered read data and
// a single-cycle acknowledge
// ----------------------------------------------------------------------
module wb_mem_bank (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  wb_pkg::wb_req_t i_req,
    input  logic            i_sel_this,
    output wb_pkg::wb_rsp_t o_rsp
);

    import wb_pkg::*;

    logic [WB_DWIDTH-1:0] mem [BANK_WORDS];

    logic [BANK_AW-1:0]   word_idx;
    logic                 accept;
    logic                 ack_q;
    logic [WB_DWIDTH-1:0] rdata_q;

    assign word_idx = i_req.adr[WORD_LSB + BANK_AW - 1:WORD_LSB];

    // Region check is done by the decoder, only i_sel_this matters here.
    // No accept right after an ack so a held request is taken once
    assign accept = i_sel_this & i_req.cyc & i_req.stb & ~ack_q;

    // ------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------
    // Write lands at the sampling edge, lane by lane
    always_ff @(posedge i_clk) begin
        if (accept && i_req.we) begin
            for (int b = 0; b < WB_SWIDTH; b++) begin
                if (i_req.sel[b]) begin
                    mem[word_idx][8*b +: 8] <= i_req.dat[8*b +: 8];
                end
            end
        end
    end

    // Read word registered, valid together with ack
    always_ff @(posedge i_clk) begin
        if (accept && !i_req.we) begin
            rdata_q <= mem[word_idx];
        end
    end

    // ------------------------------------------------------------------
    // Acknowledge
    // ------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= accept;
        end
    end

    assign o_rsp.dat = rdata_q;
    assign o_rsp.ack = ack_q;
    assign o_rsp.err = 1'b0;

endmodule

/* hw/wb_pkg.sv */
// ----------------------------------------------------------------------
// Wishbone fabric package
// Bus widths, the region address map and the request and response
// structures shared by the decoder, the memory banks and the mux
// ----------------------------------------------------------------------
package wb_pkg;

    // ------------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------------
    localparam int WB_AWIDTH = 32;
    localparam int WB_DWIDTH = 32;
    localparam int WB_SWIDTH = WB_DWIDTH / 8;

    // ------------------------------------------------------------------
    // Memory banks and address map
    // ------------------------------------------------------------------
    localparam int N_BANKS    = 4;
    localparam int BANK_WORDS = 64;
    localparam int BANK_AW    = 6;

    // Word index sits just above the byte offset
    localparam int WORD_LSB = 2;

    // Top nibble picks the region, region k maps to bank k
    localparam int REGION_MSB = 31;
    localparam int REGION_LSB = 28;
    localparam int REGION_W   = REGION_MSB - REGION_LSB + 1;

    // ------------------------------------------------------------------
    // Bus structures
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [WB_AWIDTH-1:0] adr;
        logic [WB_SWIDTH-1:0] sel;
        logic                 we;
        logic [WB_DWIDTH-1:0] dat;
        logic                 cyc;
        logic                 stb;
    } wb_req_t;

    typedef struct packed {
        logic [WB_DWIDTH-1:0] dat;
        logic                 ack;
        logic                 err;
    } wb_rsp_t;

    // One-hot, all zeros for an unmapped region
    typedef logic [N_BANKS-1:0] bank_sel_t;

endpackage

/* hw/wb_resp_mux.sv */
// ----------------------------------------------------------------------
// Wishbone response multiplexer
// Merges the bank and decoder responses into the one master response
// ----------------------------------------------------------------------
module wb_resp_mux (
    input  wb_pkg::wb_rsp_t i_bank_rsp [wb_pkg::N_BANKS],
    input  wb_pkg::wb_rsp_t i_dec_rsp,
    output wb_pkg::wb_rsp_t o_rsp
);

    import wb_pkg::*;

    logic [WB_DWIDTH-1:0] dat_or;
    logic                 ack_or;
    logic                 err_or;

    // AND-OR select, at most one responder answers in any cycle so
    // the answering slave's data passes straight through
    always_comb begin
        dat_or = i_dec_rsp.dat & {WB_DWIDTH{i_dec_rsp.err}};
        ack_or = i_dec_rsp.ack;
        err_or = i_dec_rsp.err;
        for (int k = 0; k < N_BANKS; k++) begin
            dat_or = dat_or | (i_bank_rsp[k].dat & {WB_DWIDTH{i_bank_rsp[k].ack}});
            ack_or = ack_or | i_bank_rsp[k].ack;
            err_or = err_or | i_bank_rsp[k].err;
        end
    end

    assign o_rsp.dat = dat_or;
    assign o_rsp.ack = ack_or;
    assign o_rsp.err = err_or;

endmodule

/* hw/wb_system.sv */
// ----------------------------------------------------------------------
// Wishbone memory system top level
// One master port feeding an address decoder, a row of memory banks
// and a response mux that returns a single answer
// ----------------------------------------------------------------------
module wb_system (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  wb_pkg::wb_req_t i_req,
    output wb_pkg::wb_rsp_t o_rsp
);

    import wb_pkg::*;

    bank_sel_t bank_sel;
    wb_rsp_t   dec_rsp;
    wb_rsp_t   bank_rsp [N_BANKS];

    // ------------------------------------------------------------------
    // Address decoder
    // ------------------------------------------------------------------
    wb_addr_decoder u_addr_decoder (
        .i_clk      ( i_clk    ),
        .i_rst_n    ( i_rst_n  ),
        .i_req      ( i_req    ),
        .o_bank_sel ( bank_sel ),
        .o_rsp      ( dec_rsp  )
    );

    // ------------------------------------------------------------------
    // Memory banks
    // ------------------------------------------------------------------
    // Every bank sees the whole request, its select bit qualifies it
    for (genvar k = 0; k < N_BANKS; k++) begin : g_bank
        wb_mem_bank u_bank (
            .i_clk      ( i_clk       ),
            .i_rst_n    ( i_rst_n     ),
            .i_req      ( i_req       ),
            .i_sel_this ( bank_sel[k] ),
            .o_rsp      ( bank_rsp[k] )
        );
    end

    // ------------------------------------------------------------------
    // Response mux
    // ------------------------------------------------------------------
    wb_resp_mux u_resp_mux (
        .i_bank_rsp ( bank_rsp ),
        .i_dec_rsp  ( dec_rsp  ),
        .o_rsp      ( o_rsp    )
    );

endmodule

/* list.f */
hw/wb_pkg.sv
hw/wb_addr_decoder.sv
hw/wb_mem_bank.sv
hw/wb_resp_mux.sv
hw/wb_system.sv
bench/wb_system_checker.sv
bench/tb_wb_system.sv
